/* design/dump_cfg_pkg.sv */
package dump_cfg_pkg;

    // serial line timing, in system clocks
    localparam int BIT_CLKS  = 16;                // clocks per bit
    localparam int BIT_CNT_W = $clog2(BIT_CLKS);  // bit-period counter width

    // capture buffer between sampler and transmitter
    localparam int FIFO_DEPTH = 16;               // entries, power of two
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

/* design/dump_cmd_pkg.sv */
package dump_cmd_pkg;

    // register write, op byte = {0, rsvd, addr}
    typedef struct packed {
        logic       arm;    // 0 for a write
        logic [4:0] rsvd;
        logic [1:0] addr;
        logic [7:0] data;
    } cmd_wr_t;

    // capture request, op byte = {1, rsvd}
    typedef struct packed {
        logic       arm;    // 1 for an arm
        logic [6:0] rsvd;
        logic [7:0] count;  // 0 means 256
    } cmd_arm_t;

    // first byte lands in the upper half
    typedef union packed {
        cmd_wr_t  wr;
        cmd_arm_t arm;
    } cmd_word_u;

    typedef struct packed {
        logic       en;
        logic [1:0] addr;
        logic [7:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic       en;
        logic [8:0] count;  // 1 to 256
    } arm_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } sample_t;

    typedef enum logic [1:0] {
        TRIG_NONE = 2'd0,
        TRIG_RISE = 2'd1,
        TRIG_FALL = 2'd2
    } trig_mode_e;

    localparam logic [1:0] REG_DIV  = 2'd0;
    localparam logic [1:0] REG_TRIG = 2'd1;

    localparam logic [7:0] ASCII_LF = 8'h0A;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx
    import dump_cfg_pkg::*;
    import dump_cmd_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rxd,
    output sample_t rx_byte
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e            state;
    logic [1:0]           rxd_sync;   // two-flop synchronizer
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift;
    logic                 byte_vld;
    logic                 rx_in;
    logic                 bit_end;

    assign rx_in   = rxd_sync[1];
    assign bit_end = (clk_cnt == BIT_CNT_W'(BIT_CLKS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            rxd_sync <= 2'b11;   // line idles high
            clk_cnt  <= '0;
            bit_idx  <= '0;
            byte_vld <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            byte_vld <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_in) state <= RX_START;
                end
                RX_START: begin
                    // middle of start bit, then full periods from here
                    if (clk_cnt == BIT_CNT_W'(BIT_CLKS / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_in ? RX_IDLE : RX_DATA;  // glitch check
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_end) begin
                        byte_vld <= rx_in;   // no strobe on a bad stop bit
                        state    <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) shift <= {rx_in, shift[7:1]};  // lsb first
    end

    assign rx_byte = '{valid: byte_vld, data: shift};

endmodule

/* design/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx
    import dump_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       txd,
    output logic       tx_busy
);

    logic [9:0]           frame;     // stop, data, start
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame   <= '1;          // idle high
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            if (tx_start) begin
                frame   <= {1'b1, tx_data, 1'b0};
                tx_busy <= 1'b1;
            end
        end else if (clk_cnt == BIT_CNT_W'(BIT_CLKS - 1)) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[9:1]};   // shift in idle level
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd9) tx_busy <= 1'b0;  // stop bit done
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign txd = frame[0];

    // the dump sequencer must wait out the whole frame
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy
    );

endmodule

/* design/cmd_parser.sv */
`timescale 1ns/100ps

module cmd_parser
    import dump_cmd_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t rx_byte,
    output reg_wr_t reg_wr,
    output arm_t    arm
);

    cmd_word_u cmd;
    logic      have_op;   // first byte of the pair is in
    logic      cmd_vld;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_op <= 1'b0;
            cmd_vld <= 1'b0;
        end else begin
            cmd_vld <= 1'b0;
            if (rx_byte.valid) begin
                have_op <= !have_op;
                cmd_vld <= have_op;   // second byte completes it
            end
        end
    end

    // op byte shifts up as the operand arrives
    always_ff @(posedge clk) begin
        if (rx_byte.valid) cmd <= {cmd[7:0], rx_byte.data};
    end

    assign reg_wr = '{
        en:   cmd_vld && !cmd.wr.arm,
        addr: cmd.wr.addr,
        data: cmd.wr.data
    };

    assign arm = '{
        en:    cmd_vld && cmd.arm.arm,
        count: (cmd.arm.count == 8'd0) ? 9'd256 : {1'b0, cmd.arm.count}
    };

endmodule

/* design/sig_sampler.sv */
`timescale 1ns/100ps

module sig_sampler
    import dump_cmd_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sig,
    input  reg_wr_t reg_wr,
    input  logic    run,
    output sample_t sample
);

    logic [7:0] div_reg;
    trig_mode_e trig_mode;
    logic       sig_q;
    logic       run_q;
    logic       run_rise;
    logic       trig_hit;
    logic       trig_seen;
    logic [7:0] div_cnt;
    logic [2:0] bit_cnt;
    logic       take;
    logic [7:0] shift;
    logic       smp_vld;

    assign run_rise = run && !run_q;
    assign trig_hit = (trig_mode == TRIG_RISE && sig && !sig_q) ||
                      (trig_mode == TRIG_FALL && !sig && sig_q);
    assign take     = run && !run_rise && trig_seen && (div_cnt == 8'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_reg   <= '0;
            trig_mode <= TRIG_NONE;
            sig_q     <= 1'b0;
            run_q     <= 1'b0;
            trig_seen <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            smp_vld   <= 1'b0;
        end else begin
            sig_q   <= sig;
            run_q   <= run;
            smp_vld <= take && (bit_cnt == 3'd7);   // eighth sample
            if (reg_wr.en && reg_wr.addr == REG_DIV) div_reg <= reg_wr.data;
            if (reg_wr.en && reg_wr.addr == REG_TRIG) begin
                case (reg_wr.data[1:0])
                    2'd1:    trig_mode <= TRIG_RISE;
                    2'd2:    trig_mode <= TRIG_FALL;
                    default: trig_mode <= TRIG_NONE;
                endcase
            end
            if (run_rise) begin
                trig_seen <= (trig_mode == TRIG_NONE);  // free run needs no edge
                div_cnt   <= '0;
                bit_cnt   <= '0;
            end else if (run) begin
                if (!trig_seen && trig_hit) trig_seen <= 1'b1;
                if (trig_seen) div_cnt <= (div_cnt == 8'd0) ? div_reg : div_cnt - 1'b1;
                if (take) bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) shift <= {shift[6:0], sig};   // msb first
    end

    assign sample = '{valid: smp_vld, data: shift};

    // the controller drops run only after the last byte it counts
    a_valid_in_run: assert property (
        @(posedge clk) disable iff (!rst_n) sample.valid |-> run
    );

endmodule

/* design/dump_fifo.sv */
`timescale 1ns/100ps

module dump_fifo
    import dump_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr,
    input  logic       rd,
    input  logic [7:0] din,
    output logic [7:0] dout,
    output logic       empty,
    output logic       full
);

    logic [7:0]       mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;   // extra bit tells full from empty
    logic [FIFO_AW:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign dout  = mem[rd_ptr[FIFO_AW-1:0]];   // head entry

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr && !full) wr_ptr <= wr_ptr + 1'b1;
            if (rd && !empty) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !full) mem[wr_ptr[FIFO_AW-1:0]] <= din;
    end

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (!rst_n) rd |-> !empty
    );
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n) wr |-> !full
    );

endmodule

/* design/dump_ctrl.sv */
`timescale 1ns/100ps

module dump_ctrl
    import dump_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  arm_t       arm,
    input  sample_t    sample,
    output logic       run,
    output logic       fifo_wr,
    output logic       fifo_rd,
    input  logic [7:0] fifo_dout,
    input  logic       fifo_empty,
    input  logic       fifo_full,
    output logic       tx_start,
    output logic [7:0] tx_data,
    input  logic       tx_busy,
    output logic       overflow
);

    typedef enum logic {
        S_HI,   // ready to pop and send high nibble
        S_LO    // low nibble still owed
    } seq_state_e;

    seq_state_e state;
    logic [8:0] remaining;   // bytes still to produce
    logic       lf_pend;     // capture done, trailer owed
    logic [7:0] cur_byte;
    logic       tx_ready;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib};
    endfunction

    // busy rises a cycle after the start pulse, so the pulse itself holds off
    assign tx_ready = !tx_start && !tx_busy;
    assign fifo_wr  = sample.valid && run && !fifo_full;
    assign fifo_rd  = (state == S_HI) && tx_ready && !fifo_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            remaining <= '0;
            lf_pend   <= 1'b0;
            overflow  <= 1'b0;
            state     <= S_HI;
            tx_start  <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (arm.en && !run && !lf_pend) begin
                run       <= 1'b1;
                remaining <= arm.count;
                overflow  <= 1'b0;
            end else if (sample.valid && run) begin
                remaining <= remaining - 1'b1;
                if (fifo_full) overflow <= 1'b1;   // byte dropped
                if (remaining == 9'd1) begin
                    run     <= 1'b0;
                    lf_pend <= 1'b1;
                end
            end
            if (state == S_LO && tx_ready) begin
                tx_start <= 1'b1;
                state    <= S_HI;
            end else if (fifo_rd) begin
                tx_start <= 1'b1;
                state    <= S_LO;
            end else if (state == S_HI && tx_ready && lf_pend && !run) begin
                tx_start <= 1'b1;   // fifo drained
                lf_pend  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            cur_byte <= fifo_dout;
            tx_data  <= hex_char(fifo_dout[7:4]);
        end else if (state == S_LO && tx_ready) begin
            tx_data <= hex_char(cur_byte[3:0]);
        end else if (state == S_HI && tx_ready && lf_pend && !run) begin
            tx_data <= ASCII_LF;
        end
    end

endmodule

/* design/hex_dump.sv */
`timescale 1ns/100ps

module hex_dump
    import dump_cmd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic sig,
    input  logic rx,
    output logic tx,
    output logic overflow,
    output logic capturing
);

    sample_t    rx_byte;
    reg_wr_t    reg_wr;
    arm_t       arm;
    sample_t    sample;
    logic       run;
    logic       fifo_wr;
    logic       fifo_rd;
    logic       fifo_empty;
    logic       fifo_full;
    logic [7:0] fifo_dout;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    assign capturing = run;

    uart_rx u_uart_rx (.clk, .rst_n, .rxd(rx), .rx_byte);

    cmd_parser u_cmd_parser (.clk, .rst_n, .rx_byte, .reg_wr, .arm);

    sig_sampler u_sig_sampler (.clk, .rst_n, .sig, .reg_wr, .run, .sample);

    dump_fifo u_dump_fifo (
        .clk, .rst_n,
        .wr(fifo_wr), .rd(fifo_rd),
        .din(sample.data),     // packed byte straight from the sampler
        .dout(fifo_dout), .empty(fifo_empty), .full(fifo_full)
    );

    dump_ctrl u_dump_ctrl (
        .clk, .rst_n, .arm, .sample, .run,
        .fifo_wr, .fifo_rd, .fifo_dout, .fifo_empty, .fifo_full,
        .tx_start, .tx_data, .tx_busy, .overflow
    );

    uart_tx u_uart_tx (.clk, .rst_n, .tx_start, .tx_data, .txd(tx), .tx_busy);

endmodule

/* test/tb_uart_tasks.svh */
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1, new bit enters at lsb
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// 8N1 frame on rx, starting and ending on a falling edge
task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};   // stop, data, start
    for (int i = 0; i < 10; i++) begin
        rx = frame[i];
        repeat (BIT_CLKS) @(negedge clk);
    end
endtask

// waits for a start bit on tx and samples every bit at mid-period
task automatic recv_byte(output logic [7:0] b);
    b = 8'h00;
    while (tx) @(negedge clk);
    repeat (BIT_CLKS / 2 - 1) @(negedge clk);   // centre of start bit
    for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        b[i] = tx;   // lsb first
    end
    repeat (BIT_CLKS) @(negedge clk);
    if (!tx) begin
        proto_errs++;
        $display("stop bit missing on tx after byte %h", b);
    end
endtask

`endif

/* test/tb_hex_dump.sv */
`timescale 1ns/100ps

module tb_hex_dump
    import dump_cfg_pkg::*;
    import dump_cmd_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 600 * 10 * BIT_CLKS + 20000;
    localparam int SLOW_DIV = 7;   // packing test window is SLOW_DIV+1 clocks

    logic       clk;
    logic       rst_n;
    logic       sig;
    logic       rx;
    logic       tx;
    logic       overflow;
    logic       capturing;
    logic [7:0] exp_q[$];          // bytes the next dump should carry
    logic [31:0] lfsr = 32'h7c32;
    int         value_errs = 0;
    int         proto_errs = 0;
    int         cycles = 0;

    hex_dump u_hex_dump (.clk, .rst_n, .sig, .rx, .tx, .overflow, .capturing);

    `include "tb_uart_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, the tests did not finish", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        logic [7:0] n;
        n = {4'h0, nib};
        if (nib > 4'd9) return "A" + n - 8'd10;
        return "0" + n;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        send_byte({6'd0, addr});   // op byte, arm bit clear
        send_byte(data);
        repeat (4) @(negedge clk);
    endtask

    task automatic arm_capture(input logic [7:0] count);
        send_byte(8'h80);
        send_byte(count);          // 0 asks for 256
        repeat (4) @(negedge clk);
    endtask

    // two hex characters per queued byte, then the line feed
    task automatic recv_dump(input string name);
        logic [7:0] c;
        foreach (exp_q[i]) begin
            recv_byte(c);
            check_byte(name, hex_ascii(exp_q[i][7:4]), c);
            recv_byte(c);
            check_byte(name, hex_ascii(exp_q[i][3:0]), c);
        end
        recv_byte(c);
        check_byte(name, ASCII_LF, c);
    endtask

    task automatic capture(input string name, input logic [7:0] count);
        fork
            arm_capture(count);
            recv_dump(name);
        join
    endtask

    task automatic test_constant_level();
        write_reg(REG_DIV, 8'd3);
        write_reg(REG_TRIG, 8'd0);
        sig = 1'b1;
        exp_q = '{8'hFF, 8'hFF};
        capture("const_high", 8'd2);
        sig = 1'b0;
        exp_q = '{8'h00, 8'h00};
        capture("const_low", 8'd2);
        check_flag("const_level", 1'b0, capturing);
    endtask

    task automatic test_packing_order();
        logic [15:0] bits;   // bits[15] is sampled first
        for (int i = 15; i >= 0; i--) begin
            lfsr = lfsr_step(lfsr);
            bits[i] = lfsr[0];
        end
        exp_q = '{bits[15:8], bits[7:0]};
        write_reg(REG_DIV, 8'(SLOW_DIV));
        sig = bits[15];
        fork
            arm_capture(8'd2);
            recv_dump("packing_order");
            begin
                while (!capturing) @(negedge clk);
                // first sample two clocks after run rises, change mid-window
                repeat (2 + (SLOW_DIV + 1) / 2) @(negedge clk);
                for (int k = 14; k >= 0; k--) begin
                    sig = bits[k];
                    repeat (SLOW_DIV + 1) @(negedge clk);
                end
            end
        join
    endtask

    task automatic test_trigger_rise();
        logic quiet;
        quiet = 1'b1;
        write_reg(REG_DIV, 8'd3);
        write_reg(REG_TRIG, 8'd1);
        sig = 1'b0;
        arm_capture(8'd1);
        repeat (20 * BIT_CLKS) begin
            @(negedge clk);
            if (!tx) quiet = 1'b0;
        end
        if (!quiet) begin
            proto_errs++;
            $display("tx sent data before the trigger edge");
        end
        check_flag("trigger_wait", 1'b1, capturing);
        sig = 1'b1;
        exp_q = '{8'hFF};
        recv_dump("trigger_rise");
        write_reg(REG_TRIG, 8'd0);
    endtask

    task automatic test_ignored_writes();
        write_reg(REG_DIV, 8'd3);
        write_reg(2'd3, 8'h02);    // unused address
        sig = 1'b1;
        exp_q = '{8'hFF, 8'hFF};
        capture("ignored_addr", 8'd2);
        sig = 1'b0;
        exp_q.delete();
        repeat (16) exp_q.push_back(8'h00);
        fork
            begin
                arm_capture(8'd16);
                arm_capture(8'd4);   // lands while run is still high
            end
            recv_dump("ignored_rearm");
        join
        check_flag("ignored_rearm", 1'b0, capturing);
        check_flag("ignored_rearm", 1'b0, overflow);
    endtask

    task automatic test_overflow();
        logic [7:0] c;
        int chars;
        chars = 0;
        write_reg(REG_DIV, 8'd0);
        sig = 1'b1;
        fork
            arm_capture(8'd0);
            begin
                recv_byte(c);
                while (c != ASCII_LF) begin
                    check_byte("overflow_dump", "F", c);
                    chars++;
                    recv_byte(c);
                end
            end
        join
        if (chars >= 512 || chars % 2 != 0) begin
            proto_errs++;
            $display("overflow dump sent %0d characters, not a short run of pairs", chars);
        end
        check_flag("overflow_set", 1'b1, overflow);
        exp_q = '{8'hFF};
        capture("overflow_clear", 8'd1);
        check_flag("overflow_clear", 1'b0, overflow);
    endtask

    initial begin
        rst_n = 1'b0;
        rx = 1'b1;                 // idle line
        sig = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_flag("reset", 1'b0, overflow);
        check_flag("reset", 1'b0, capturing);
        check_flag("reset", 1'b1, tx);
        test_constant_level();
        test_packing_order();
        test_trigger_rise();
        test_ignored_writes();
        test_overflow();
        $display("value errors: %0d, other errors: %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+test
design/dump_cfg_pkg.sv
design/dump_cmd_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_parser.sv
design/sig_sampler.sv
design/dump_fifo.sv
design/dump_ctrl.sv
design/hex_dump.sv
test/tb_hex_dump.sv

/* Makefile */
TOP := tb_hex_dump

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "TESTBENCH FAILED" sim.log
	@grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module hex_dump

clean:
	rm -rf obj_dir sim.log
